//--- coeff_quantizer.sv
// Two-stage luma quantizer; lane 0 of the first word of every block is treated as DC
`default_nettype none
`include "hdl_computing_params.svh"

module coeff_quantizer
    import hdl_computing_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_rst,
    input  wire logic        i_start,
    input  wire logic        i_empty,
    input  wire coeff_word_t i_data,
    output logic             o_pop,
    input  wire logic        i_full,
    output logic             o_push,
    output level_word_t      o_data
);

    localparam int WCNT_W = (`HC_WORDS_PER_BLOCK > 1) ? $clog2(`HC_WORDS_PER_BLOCK) : 1;

    typedef struct packed {
        logic        neg;
        logic        nz;
        logic        dc;
        logic [31:0] prod;
    } lane_s1_t;

    lane_s1_t [`HC_LANES-1:0] s1_d;
    lane_s1_t [`HC_LANES-1:0] s1_q;
    level_word_t              lv_d;
    logic                     v1_q;
    logic                     v2_q;
    logic                     ld1;
    logic                     ld2;
    logic [WCNT_W-1:0]        wcnt_q;

    // Stall chain, a stage loads when it is empty or draining
    assign o_push = v2_q && !i_full;
    assign ld2    = !v2_q || o_push;
    assign ld1    = !v1_q || ld2;
    assign o_pop  = !i_empty && ld1;

    // ------------------------------------------------------------------------
    // Stage 1: magnitude, threshold, product
    always_comb begin
        logic [15:0] mag;
        logic [15:0] iq;
        logic [15:0] zth;
        logic        dc;
        for (int i = 0; i < `HC_LANES; i++) begin
            dc  = (i == 0) && (wcnt_q == '0);
            iq  = dc ? `HC_DC_IQ : `HC_AC_IQ;
            zth = dc ? `HC_DC_ZTHRESH : `HC_AC_ZTHRESH;
            mag = i_data[i][15] ? 16'(-i_data[i]) : 16'(i_data[i]);
            s1_d[i].neg  = i_data[i][15];
            s1_d[i].nz   = mag > zth;
            s1_d[i].dc   = dc;
            s1_d[i].prod = 32'(mag) * 32'(iq);
        end
    end

    // Stage 2: bias, shift, clamp, sign
    always_comb begin
        logic [31:0] sum;
        logic [31:0] q;
        for (int i = 0; i < `HC_LANES; i++) begin
            sum = s1_q[i].prod + (s1_q[i].dc ? `HC_DC_BIAS : `HC_AC_BIAS);
            q   = sum >> `HC_QFIX;
            if (q > 32'(`HC_MAX_LEVEL)) q = 32'(`HC_MAX_LEVEL);
            if (!s1_q[i].nz) begin
                lv_d[i] = '0;
            end else if (s1_q[i].neg) begin
                lv_d[i] = -level_t'(q);
            end else begin
                lv_d[i] = level_t'(q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            if (ld1) v1_q <= o_pop;
            if (ld2) v2_q <= v1_q;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) s1_q <= s1_d;
        if (ld2 && v1_q) o_data <= lv_d;
    end

    // Word position inside the block
    always_ff @(posedge clk) begin
        if (i_rst || i_start) begin
            wcnt_q <= '0;
        end else if (o_pop) begin
            wcnt_q <= (wcnt_q == WCNT_W'(`HC_WORDS_PER_BLOCK - 1)) ? '0 : wcnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- ctrl_regs.sv
// Register file; ack one cycle after stb, config writes ignored while busy, STATUS bit0 busy bit1 done
`default_nettype none
`include "hdl_computing_params.svh"

module ctrl_regs
    import hdl_computing_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     i_rst,
    input  wire wb_req_t  i_req,
    output wb_rsp_t       o_rsp,
    input  wire logic     i_job_done,
    output logic          o_start,
    output job_cfg_t      o_job
);

    logic [2:0]           reg_idx;
    logic                 ack_q;
    logic                 busy_q;
    logic                 done_q;
    logic                 start_q;
    logic                 wr_acc;
    logic                 start_ok;
    logic [`HC_REG_W-1:0] rdata_mux;
    logic [`HC_REG_W-1:0] rdata_q;
    job_cfg_t             job_q;

    assign reg_idx  = i_req.adr[4:2];
    assign wr_acc   = ack_q && i_req.cyc && i_req.stb && i_req.we;
    assign start_ok = wr_acc && (reg_idx == 3'(`HC_REG_CTRL)) && i_req.dat[0] && !busy_q;

    always_comb begin
        case (reg_idx)
            3'(`HC_REG_STATUS): rdata_mux = {{(`HC_REG_W-2){1'b0}}, done_q, busy_q};
            3'(`HC_REG_SRC):    rdata_mux = job_q.src_addr;
            3'(`HC_REG_DST):    rdata_mux = job_q.dst_addr;
            3'(`HC_REG_NBLK):   rdata_mux = `HC_REG_W'(job_q.num_blocks);
            3'(`HC_REG_TYPE):   rdata_mux = `HC_ACTION_TYPE;
            default:            rdata_mux = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Bus handshake and job control
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ack_q   <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
            job_q   <= '0;
        end else begin
            ack_q   <= i_req.cyc && i_req.stb && !ack_q;
            start_q <= start_ok;
            if (start_ok) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (i_job_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (wr_acc && !busy_q) begin
                case (reg_idx)
                    3'(`HC_REG_SRC):  job_q.src_addr   <= i_req.dat[`HC_ADDR_W-1:0];
                    3'(`HC_REG_DST):  job_q.dst_addr   <= i_req.dat[`HC_ADDR_W-1:0];
                    3'(`HC_REG_NBLK): job_q.num_blocks <= i_req.dat[15:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data sampled on the first stb cycle
    always_ff @(posedge clk) begin
        if (i_req.cyc && i_req.stb && !ack_q) begin
            rdata_q <= rdata_mux;
        end
    end

    always_comb begin
        o_rsp.ack = ack_q;
        o_rsp.dat = {{(`HC_MEM_W-`HC_REG_W){1'b0}}, rdata_q};
    end

    assign o_start = start_q;
    assign o_job   = job_q;

endmodule

`default_nettype wire

//--- hdl_computing.sv
// Accelerator top; all three buses share clk and the synchronous reset
`default_nettype none

module hdl_computing
    import hdl_computing_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    i_rst,
    input  wire wb_req_t i_reg_req,
    output wb_rsp_t      o_reg_rsp,
    output wb_req_t      o_rd_req,
    input  wire wb_rsp_t i_rd_rsp,
    output wb_req_t      o_wr_req,
    input  wire wb_rsp_t i_wr_rsp
);

    logic        start;
    logic        job_done;
    job_cfg_t    job;
    logic        in_push;
    logic        in_pop;
    logic        in_full;
    logic        in_empty;
    coeff_word_t in_wdata;
    coeff_word_t in_rdata;
    logic        out_push;
    logic        out_pop;
    logic        out_full;
    logic        out_empty;
    level_word_t out_wdata;
    level_word_t out_rdata;

    ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_req      (i_reg_req),
        .o_rsp      (o_reg_rsp),
        .i_job_done (job_done),
        .o_start    (start),
        .o_job      (job)
    );

    host_mem_reader u_reader (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_start     (start),
        .i_job       (job),
        .o_req       (o_rd_req),
        .i_rsp       (i_rd_rsp),
        .i_fifo_full (in_full),
        .o_push      (in_push),
        .o_data      (in_wdata)
    );

    sync_fifo #(.T(coeff_word_t)) u_in_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (in_push),
        .i_data  (in_wdata),
        .i_pop   (in_pop),
        .o_data  (in_rdata),
        .o_full  (in_full),
        .o_empty (in_empty)
    );

    coeff_quantizer u_quant (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_start (start),
        .i_empty (in_empty),
        .i_data  (in_rdata),
        .o_pop   (in_pop),
        .i_full  (out_full),
        .o_push  (out_push),
        .o_data  (out_wdata)
    );

    sync_fifo #(.T(level_word_t)) u_out_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (out_push),
        .i_data  (out_wdata),
        .i_pop   (out_pop),
        .o_data  (out_rdata),
        .o_full  (out_full),
        .o_empty (out_empty)
    );

    host_mem_writer u_writer (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (start),
        .i_job      (job),
        .i_empty    (out_empty),
        .i_data     (out_rdata),
        .o_pop      (out_pop),
        .o_req      (o_wr_req),
        .i_rsp      (i_wr_rsp),
        .o_job_done (job_done)
    );

endmodule

`default_nettype wire

//--- hdl_computing_params.svh
// Build constants; FIFO depth must be a power of two and only the luma quantizer set is provided
`ifndef HDL_COMPUTING_PARAMS_SVH
`define HDL_COMPUTING_PARAMS_SVH

`define HC_ADDR_W           32
`define HC_REG_W            32
`define HC_MEM_W            64
`define HC_LANES            4
`define HC_WORDS_PER_BLOCK  4
`define HC_FIFO_DEPTH       8

// Register word offsets, byte address is offset * 4
`define HC_REG_CTRL         0
`define HC_REG_STATUS       1
`define HC_REG_SRC          2
`define HC_REG_DST          3
`define HC_REG_NBLK         4
`define HC_REG_TYPE         5

`define HC_ACTION_TYPE      32'h1014_0001

// ----------------------------------------------------------------------------
// Quantizer, luma set
`define HC_QFIX             17
`define HC_MAX_LEVEL        2047
`define HC_DC_IQ            16'h1555
`define HC_DC_BIAS          32'h0000_C000
`define HC_DC_ZTHRESH       16'h000F
`define HC_AC_IQ            16'h1111
`define HC_AC_BIAS          32'h0000_DC00
`define HC_AC_ZTHRESH       16'h0011

`endif

//--- hdl_computing_pkg.sv
// Shared types; register bus reuses the memory bus structs with only the low 32 data bits used
`default_nettype none
`include "hdl_computing_params.svh"

package hdl_computing_pkg;

    typedef logic signed [15:0] coeff_t;
    typedef coeff_t [`HC_LANES-1:0] coeff_word_t;

    typedef logic signed [11:0] level_t;
    typedef level_t [`HC_LANES-1:0] level_word_t;

    typedef struct packed {
        logic [`HC_ADDR_W-1:0] src_addr;
        logic [`HC_ADDR_W-1:0] dst_addr;
        logic [15:0]           num_blocks;
    } job_cfg_t;

    // Wishbone classic master request
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`HC_ADDR_W-1:0]   adr;
        logic [`HC_MEM_W-1:0]    dat;
        logic [`HC_MEM_W/8-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`HC_MEM_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- host_mem_reader.sv
// One outstanding single read at a time; a read is issued only when the input FIFO has room
`default_nettype none
`include "hdl_computing_params.svh"

module host_mem_reader
    import hdl_computing_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     i_rst,
    input  wire logic     i_start,
    input  wire job_cfg_t i_job,
    output wb_req_t       o_req,
    input  wire wb_rsp_t  i_rsp,
    input  wire logic     i_fifo_full,
    output logic          o_push,
    output coeff_word_t   o_data
);

    localparam int NBLK_W = $bits(job_cfg_t) - 2 * `HC_ADDR_W;
    localparam int CNT_W  = NBLK_W + $clog2(`HC_WORDS_PER_BLOCK) + 1;

    logic                  cyc_q;
    logic [`HC_ADDR_W-1:0] adr_q;
    logic [CNT_W-1:0]      left_q;
    logic                  ack_edge;

    assign ack_edge = cyc_q && i_rsp.ack;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cyc_q  <= 1'b0;
            left_q <= '0;
        end else if (i_start) begin
            left_q <= CNT_W'(i_job.num_blocks) * CNT_W'(`HC_WORDS_PER_BLOCK);
        end else if (cyc_q) begin
            if (i_rsp.ack) begin
                cyc_q  <= 1'b0;
                left_q <= left_q - 1'b1;
            end
        end else if (left_q != '0 && !i_fifo_full) begin
            cyc_q <= 1'b1;
        end
    end

    // Next word address
    always_ff @(posedge clk) begin
        if (i_start) begin
            adr_q <= i_job.src_addr;
        end else if (ack_edge) begin
            adr_q <= adr_q + `HC_ADDR_W'(`HC_MEM_W / 8);
        end
    end

    always_comb begin
        o_req     = '0;
        o_req.cyc = cyc_q;
        o_req.stb = cyc_q;
        o_req.adr = adr_q;
        o_req.sel = '1;
    end

    assign o_push = ack_edge;
    assign o_data = i_rsp.dat;

endmodule

`default_nettype wire

//--- host_mem_writer.sv
// Single writes with all byte lanes; a job of zero blocks completes at once
`default_nettype none
`include "hdl_computing_params.svh"

module host_mem_writer
    import hdl_computing_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_rst,
    input  wire logic        i_start,
    input  wire job_cfg_t    i_job,
    input  wire logic        i_empty,
    input  wire level_word_t i_data,
    output logic             o_pop,
    output wb_req_t          o_req,
    input  wire wb_rsp_t     i_rsp,
    output logic             o_job_done
);

    localparam int NBLK_W = $bits(job_cfg_t) - 2 * `HC_ADDR_W;
    localparam int CNT_W  = NBLK_W + $clog2(`HC_WORDS_PER_BLOCK) + 1;

    logic                  cyc_q;
    logic                  done_q;
    logic [`HC_ADDR_W-1:0] adr_q;
    logic [CNT_W-1:0]      left_q;
    logic                  ack_edge;
    coeff_word_t           wr_word;

    assign ack_edge = cyc_q && i_rsp.ack;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
            left_q <= '0;
        end else begin
            done_q <= (ack_edge && left_q == CNT_W'(1)) ||
                      (i_start && i_job.num_blocks == '0);
            if (i_start) begin
                left_q <= CNT_W'(i_job.num_blocks) * CNT_W'(`HC_WORDS_PER_BLOCK);
            end else if (cyc_q) begin
                if (i_rsp.ack) begin
                    cyc_q  <= 1'b0;
                    left_q <= left_q - 1'b1;
                end
            end else if (left_q != '0 && !i_empty) begin
                cyc_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            adr_q <= i_job.dst_addr;
        end else if (ack_edge) begin
            adr_q <= adr_q + `HC_ADDR_W'(`HC_MEM_W / 8);
        end
    end

    // Head of FIFO stays put until the ack pops it
    always_comb begin
        for (int i = 0; i < `HC_LANES; i++) begin
            wr_word[i] = coeff_t'(i_data[i]);
        end
        o_req     = '0;
        o_req.cyc = cyc_q;
        o_req.stb = cyc_q;
        o_req.we  = 1'b1;
        o_req.adr = adr_q;
        o_req.dat = wr_word;
        o_req.sel = '1;
    end

    assign o_pop      = ack_edge;
    assign o_job_done = done_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, exit status 0 only when the log shows a pass
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -j 0 --top-module tb_hdl_computing -f src.f -o tb_hdl_computing \
    > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_hdl_computing > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
fi

if grep -qx "sim passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1

//--- src.f
+incdir+.
hdl_computing_pkg.sv
ctrl_regs.sv
host_mem_reader.sv
sync_fifo.sv
coeff_quantizer.sv
host_mem_writer.sv
hdl_computing.sv
tb_host_mem.sv
tb_hdl_computing.sv

//--- sync_fifo.sv
// Show-ahead FIFO; push while full and pop while empty must not be issued
`default_nettype none
`include "hdl_computing_params.svh"

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `HC_FIFO_DEPTH
) (
    input  wire logic clk,
    input  wire logic i_rst,
    input  wire logic i_push,
    input  wire T     i_data,
    input  wire logic i_pop,
    output T          o_data,
    output logic      o_full,
    output logic      o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= ptr_next(wr_ptr);
            if (i_pop)  rd_ptr <= ptr_next(rd_ptr);
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (i_pop && !i_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];
    assign o_full  = (count == (AW+1)'(DEPTH));
    assign o_empty = (count == '0);

endmodule

`default_nettype wire

//--- tb_hdl_computing.sv
// Testbench for hdl_computing; stops at the first mismatch and relies on jobs not overlapping in memory
`default_nettype none
`include "hdl_computing_params.svh"

module tb_hdl_computing
    import hdl_computing_pkg::*;
();

    localparam int TOTAL_WORDS    = (1 + 12 + 2 + 2) * `HC_WORDS_PER_BLOCK;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_WORDS + 2000;

    logic        clk = 1'b0;
    logic        i_rst;
    wb_req_t     reg_req;
    wb_rsp_t     reg_rsp;
    wb_req_t     rd_req;
    wb_rsp_t     rd_rsp;
    wb_req_t     wr_req;
    wb_rsp_t     wr_rsp;
    logic        bd_we;
    logic [31:0] bd_adr;
    logic [63:0] bd_dat;
    logic [63:0] bd_rdat;
    int unsigned write_count;
    int          cycles = 0;
    int unsigned done_pulses = 0;
    logic [63:0] stim [logic [28:0]];
    coeff_t      directed [16];

    hdl_computing DUT (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_reg_req (reg_req),
        .o_reg_rsp (reg_rsp),
        .o_rd_req  (rd_req),
        .i_rd_rsp  (rd_rsp),
        .o_wr_req  (wr_req),
        .i_wr_rsp  (wr_rsp)
    );

    tb_host_mem u_mem (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_rd_req      (rd_req),
        .o_rd_rsp      (rd_rsp),
        .i_wr_req      (wr_req),
        .o_wr_rsp      (wr_rsp),
        .i_bd_we       (bd_we),
        .i_bd_adr      (bd_adr),
        .i_bd_dat      (bd_dat),
        .o_bd_dat      (bd_rdat),
        .o_write_count (write_count)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (DUT.job_done) begin
            done_pulses <= done_pulses + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, the DUT never finished", cycles));
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                     name, got, exp));
        end
    endtask

    task automatic check_mem_word(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got 0x%016h expected 0x%016h",
                                     name, got, exp));
        end
    endtask

    task automatic check_level_word(input string name, input level_word_t got,
                                    input level_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got 0x%012h expected 0x%012h",
                                     name, got, exp));
        end
    endtask

    // Magnitude above zthresh gives (a*iq + bias) >> QFIX, capped, with the input sign
    function automatic level_t ref_quantize(input coeff_t c, input logic dc);
        int a;
        int q;
        int iq;
        int bias;
        int zth;
        iq   = dc ? int'(`HC_DC_IQ) : int'(`HC_AC_IQ);
        bias = dc ? int'(`HC_DC_BIAS) : int'(`HC_AC_BIAS);
        zth  = dc ? int'(`HC_DC_ZTHRESH) : int'(`HC_AC_ZTHRESH);
        a    = (c < 0) ? -int'(c) : int'(c);
        if (a <= zth) begin
            return '0;
        end
        q = (a * iq + bias) >> `HC_QFIX;
        if (q > `HC_MAX_LEVEL) begin
            q = `HC_MAX_LEVEL;
        end
        return (c < 0) ? level_t'(-q) : level_t'(q);
    endfunction

    function automatic level_word_t ref_level_word(input coeff_word_t w, input logic first);
        level_word_t r;
        for (int i = 0; i < `HC_LANES; i++) begin
            r[i] = ref_quantize(w[i], first && (i == 0));
        end
        return r;
    endfunction

    function automatic logic [63:0] guard_word(input logic [31:0] a);
        return {a ^ 32'h5A5A_0F0F, ~a};
    endfunction

    // Register bus, one Wishbone transfer then one idle cycle
    task automatic reg_access(input logic we, input int idx, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        reg_req.cyc = 1'b1;
        reg_req.stb = 1'b1;
        reg_req.we  = we;
        reg_req.adr = 32'(idx * 4);
        reg_req.dat = {32'h0, wdata};
        reg_req.sel = 8'h0F;
        do begin
            @(negedge clk);
        end while (!reg_rsp.ack);
        rdata = reg_rsp.dat[31:0];
        @(posedge clk);
        #1;
        reg_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input int idx, input logic [31:0] wdata);
        logic [31:0] unused;
        reg_access(1'b1, idx, wdata, unused);
    endtask

    task automatic reg_read(input int idx, output logic [31:0] rdata);
        reg_access(1'b0, idx, 32'h0, rdata);
    endtask

    task automatic poke(input logic [31:0] addr, input logic [63:0] data);
        bd_we  = 1'b1;
        bd_adr = addr;
        bd_dat = data;
        @(posedge clk);
        #1;
        bd_we = 1'b0;
    endtask

    task automatic peek(input logic [31:0] addr, output logic [63:0] data);
        bd_adr = addr;
        @(negedge clk);
        data = bd_rdat;
        @(posedge clk);
        #1;
    endtask

    task automatic load_source(input logic [31:0] addr, input coeff_word_t w);
        stim[addr[31:3]] = w;
        poke(addr, w);
    endtask

    task automatic start_job(input logic [31:0] src, input logic [31:0] dst, input int nblk);
        poke(dst - 32'd8, guard_word(dst - 32'd8));
        poke(dst + 32'(nblk * 32), guard_word(dst + 32'(nblk * 32)));
        reg_write(`HC_REG_SRC, src);
        reg_write(`HC_REG_DST, dst);
        reg_write(`HC_REG_NBLK, 32'(nblk));
        reg_write(`HC_REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        do begin
            reg_read(`HC_REG_STATUS, st);
        end while (!st[1]);
    endtask

    // Each level lands sign extended to 16 bits in its lane
    task automatic check_job(input logic [31:0] src, input logic [31:0] dst, input int nblk);
        logic [63:0] dword;
        logic [63:0] exp_word;
        level_word_t got;
        level_word_t exp;
        coeff_word_t cw;
        for (int w = 0; w < nblk * `HC_WORDS_PER_BLOCK; w++) begin
            cw  = stim[src[31:3] + 29'(w)];
            exp = ref_level_word(cw, (w % `HC_WORDS_PER_BLOCK) == 0);
            peek(dst + 32'(8 * w), dword);
            for (int i = 0; i < `HC_LANES; i++) begin
                got[i]                = dword[16*i +: 12];
                exp_word[16*i +: 16] = {{4{exp[i][11]}}, exp[i]};
            end
            check_level_word($sformatf("dst 0x%08h word %0d", dst, w), got, exp);
            check_mem_word($sformatf("dst 0x%08h word %0d", dst, w), dword, exp_word);
        end
        peek(dst - 32'd8, dword);
        check_mem_word("guard below destination", dword, guard_word(dst - 32'd8));
        peek(dst + 32'(nblk * 32), dword);
        check_mem_word("guard above destination", dword, guard_word(dst + 32'(nblk * 32)));
    endtask

    initial begin
        coeff_word_t cw;
        logic [31:0] rd;
        int unsigned writes_before;
        int unsigned dones_before;
        void'($urandom(1));
        i_rst   = 1'b1;
        reg_req = '0;
        bd_we   = 1'b0;
        bd_adr  = '0;
        bd_dat  = '0;
        // Thresholds, signs and the largest magnitudes; these constants never reach the clamp
        directed = '{16'sd16, 16'sd0, 16'sd17, 16'sd18,
                     -16'sd18, -16'sd17, 16'sd32767, 16'sh8000,
                     16'sd15, -16'sd16, 16'sd100, -16'sd1000,
                     16'sd16384, -16'sd16384, 16'sd1, 16'sd2047};
        repeat (2) @(posedge clk);
        #1;
        i_rst = 1'b0;
        @(posedge clk);
        #1;

        check_reg("bus strobes after reset",
                  32'({reg_rsp.ack, rd_req.cyc, rd_req.stb, wr_req.cyc, wr_req.stb}), 32'h0);
        reg_read(`HC_REG_STATUS, rd);
        check_reg("STATUS after reset", rd, 32'h0);
        reg_read(`HC_REG_TYPE, rd);
        check_reg("TYPE", rd, `HC_ACTION_TYPE);
        reg_write(`HC_REG_SRC, 32'h0000_1000);
        reg_write(`HC_REG_DST, 32'h0000_8000);
        reg_write(`HC_REG_NBLK, 32'h1);
        reg_read(`HC_REG_SRC, rd);
        check_reg("SRC", rd, 32'h0000_1000);
        reg_read(`HC_REG_DST, rd);
        check_reg("DST", rd, 32'h0000_8000);
        reg_read(`HC_REG_NBLK, rd);
        check_reg("NBLK", rd, 32'h1);

        // ------------------------------------------------------------------------
        // One directed block
        for (int w = 0; w < `HC_WORDS_PER_BLOCK; w++) begin
            for (int l = 0; l < `HC_LANES; l++) begin
                cw[l] = directed[w * `HC_LANES + l];
            end
            load_source(32'h0000_1000 + 32'(8 * w), cw);
        end
        start_job(32'h0000_1000, 32'h0000_8000, 1);
        wait_done();
        check_job(32'h0000_1000, 32'h0000_8000, 1);

        // ------------------------------------------------------------------------
        // Twelve random blocks, half the lanes near the thresholds
        for (int w = 0; w < 12 * `HC_WORDS_PER_BLOCK; w++) begin
            for (int l = 0; l < `HC_LANES; l++) begin
                if ($urandom_range(1, 0) == 1) begin
                    cw[l] = coeff_t'($urandom);
                end else begin
                    cw[l] = coeff_t'(int'($urandom_range(63, 0)) - 32);
                end
            end
            load_source(32'h0000_2000 + 32'(8 * w), cw);
        end
        start_job(32'h0000_2000, 32'h0000_9000, 12);
        wait_done();
        check_job(32'h0000_2000, 32'h0000_9000, 12);

        // ------------------------------------------------------------------------
        // Busy status and a start that must be ignored
        writes_before = write_count;
        dones_before  = done_pulses;
        start_job(32'h0000_2000, 32'h0000_A000, 2);
        reg_read(`HC_REG_STATUS, rd);
        check_reg("STATUS while busy", rd, 32'h1);
        reg_write(`HC_REG_CTRL, 32'h1);
        wait_done();
        repeat (100) @(posedge clk);
        #1;
        check_reg("words written by one job", 32'(write_count - writes_before), 32'd8);
        check_reg("done pulses of one job", 32'(done_pulses - dones_before), 32'd1);
        reg_read(`HC_REG_STATUS, rd);
        check_reg("STATUS after job", rd, 32'h2);
        check_job(32'h0000_2000, 32'h0000_A000, 2);

        // Next start clears done
        start_job(32'h0000_2000, 32'h0000_B000, 2);
        reg_read(`HC_REG_STATUS, rd);
        check_reg("STATUS after restart", rd, 32'h1);
        wait_done();
        check_job(32'h0000_2000, 32'h0000_B000, 2);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_host_mem.sv
// Sparse 64-bit host memory for simulation only; acks wait 0 to 3 cycles, writes honor sel, unwritten words read 0
`default_nettype none
`include "hdl_computing_params.svh"

module tb_host_mem
    import hdl_computing_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    input  wire wb_req_t               i_rd_req,
    output wb_rsp_t                    o_rd_rsp,
    input  wire wb_req_t               i_wr_req,
    output wb_rsp_t                    o_wr_rsp,
    input  wire logic                  i_bd_we,
    input  wire logic [`HC_ADDR_W-1:0] i_bd_adr,
    input  wire logic [`HC_MEM_W-1:0]  i_bd_dat,
    output logic [`HC_MEM_W-1:0]       o_bd_dat,
    output int unsigned                o_write_count
);

    logic [`HC_MEM_W-1:0] mem [logic [28:0]];
    logic [1:0]           rd_cnt;
    logic [1:0]           rd_dly;
    logic [1:0]           wr_cnt;
    logic [1:0]           wr_dly;

    function automatic logic [`HC_MEM_W-1:0] fetch(input logic [`HC_ADDR_W-1:0] adr);
        if (mem.exists(adr[31:3])) begin
            return mem[adr[31:3]];
        end
        return '0;
    endfunction

    // Read port answers reads only, write port answers writes only
    always_comb begin
        o_rd_rsp.ack = i_rd_req.cyc && i_rd_req.stb && !i_rd_req.we && (rd_cnt == rd_dly);
        o_rd_rsp.dat = fetch(i_rd_req.adr);
        o_wr_rsp.ack = i_wr_req.cyc && i_wr_req.stb && i_wr_req.we && (wr_cnt == wr_dly);
        o_wr_rsp.dat = '0;
        o_bd_dat     = fetch(i_bd_adr);
    end

    always @(posedge clk) begin
        logic                 rst;
        logic                 rd_act;
        logic                 rd_fire;
        logic                 wr_act;
        logic                 wr_fire;
        logic [`HC_MEM_W-1:0] merged;
        rst     = i_rst;
        rd_act  = i_rd_req.cyc && i_rd_req.stb && !i_rd_req.we;
        rd_fire = rd_act && o_rd_rsp.ack;
        wr_act  = i_wr_req.cyc && i_wr_req.stb && i_wr_req.we;
        wr_fire = wr_act && o_wr_rsp.ack;
        if (wr_fire) begin
            merged = fetch(i_wr_req.adr);
            for (int b = 0; b < `HC_MEM_W / 8; b++) begin
                if (i_wr_req.sel[b]) begin
                    merged[8*b +: 8] = i_wr_req.dat[8*b +: 8];
                end
            end
            mem[i_wr_req.adr[31:3]] = merged;
            o_write_count = o_write_count + 1;
        end
        if (i_bd_we) begin
            mem[i_bd_adr[31:3]] = i_bd_dat;
        end
        // Wait states move just after the edge
        #1;
        if (rst) begin
            rd_cnt        = '0;
            rd_dly        = '0;
            wr_cnt        = '0;
            wr_dly        = '0;
            o_write_count = 0;
        end else begin
            if (rd_fire) begin
                rd_cnt = '0;
                rd_dly = 2'($urandom_range(3, 0));
            end else if (rd_act) begin
                rd_cnt = rd_cnt + 2'd1;
            end
            if (wr_fire) begin
                wr_cnt = '0;
                wr_dly = 2'($urandom_range(3, 0));
            end else if (wr_act) begin
                wr_cnt = wr_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire
